/* compile.f */
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_sequencer.sv
hw/rv_counters.sv
hw/rv_datapath.sv
hw/rv_core.sv
verif/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit 1
fi
exit 0

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
  import rv_isa_pkg::*;

  logic        clk;
  logic        rst_n = 1'b0;
  logic        imem_valid, dmem_valid, dmem_we, ebreak;
  logic        imem_ready = 1'b0;
  logic        imem_rvalid = 1'b0;
  logic [31:0] imem_rdata = '0;
  logic        dmem_ready = 1'b0;
  logic        dmem_rvalid = 1'b0;
  logic [31:0] dmem_rdata = '0;
  logic [31:0] imem_addr, dmem_addr, dmem_wdata;

  logic [31:0] imem [1024];
  logic [31:0] dmem [1024];
  logic [31:0] prog [$];
  logic [31:0] exp_q [$];
  logic [31:0] wr_addr_q [$];
  string       cur_test = "none";

  // Memory model state
  logic        i_acc = 0, i_busy = 0, i_wait = 0;
  logic [31:0] i_raddr, i_wait_addr;
  int          i_cnt;
  logic        d_acc = 0, d_busy = 0, d_wait = 0, d_wait_we;
  logic [31:0] d_raddr, d_wait_addr, d_wait_wdata;
  int          d_cnt;

  rv_core rv_core_inst (
    .clk(clk), .rst_n(rst_n),
    .imem_valid(imem_valid), .imem_ready(imem_ready), .imem_addr(imem_addr),
    .imem_rvalid(imem_rvalid), .imem_rdata(imem_rdata),
    .dmem_valid(dmem_valid), .dmem_ready(dmem_ready), .dmem_we(dmem_we),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_rvalid(dmem_rvalid), .dmem_rdata(dmem_rdata),
    .ebreak(ebreak)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s: expected %h, actual %h", cur_test, what, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  // --------------------------------------------------
  // Instruction memory model
  // --------------------------------------------------
  always @(negedge clk) begin
    if (!rst_n) begin
      imem_ready = 0;
      imem_rvalid = 0;
      i_acc = 0;
      i_busy = 0;
      i_wait = 0;
    end else begin
      imem_rvalid = 0;
      if (i_acc) begin
        i_busy = 1;
        i_cnt = $urandom % 3;
        i_acc = 0;
      end
      if (i_busy) begin
        if (i_cnt == 0) begin
          imem_rvalid = 1;
          imem_rdata = imem[i_raddr[11:2]];
          i_busy = 0;
        end else begin
          i_cnt--;
        end
      end
      if (i_wait) begin
        check("imem_valid held", 1, imem_valid);
        check("imem_addr held", i_wait_addr, imem_addr);
      end
      imem_ready = ($urandom % 4) != 0;
      i_wait = imem_valid && !imem_ready;
      i_wait_addr = imem_addr;
      if (imem_valid && imem_ready) begin
        i_acc = 1;
        i_raddr = imem_addr;
      end
    end
  end

  // --------------------------------------------------
  // Data memory model
  // --------------------------------------------------
  always @(negedge clk) begin
    if (!rst_n) begin
      dmem_ready = 0;
      dmem_rvalid = 0;
      d_acc = 0;
      d_busy = 0;
      d_wait = 0;
    end else begin
      dmem_rvalid = 0;
      if (d_acc) begin
        d_busy = 1;
        d_cnt = $urandom % 4;
        d_acc = 0;
      end
      if (d_busy) begin
        if (d_cnt == 0) begin
          dmem_rvalid = 1;
          dmem_rdata = dmem[d_raddr[11:2]];
          d_busy = 0;
        end else begin
          d_cnt--;
        end
      end
      if (d_wait) begin
        check("dmem_valid held", 1, dmem_valid);
        check("dmem_we held", {31'b0, d_wait_we}, {31'b0, dmem_we});
        check("dmem_addr held", d_wait_addr, dmem_addr);
        if (d_wait_we) check("dmem_wdata held", d_wait_wdata, dmem_wdata);
      end
      dmem_ready = ($urandom % 3) != 0;
      d_wait = dmem_valid && !dmem_ready;
      d_wait_we = dmem_we;
      d_wait_addr = dmem_addr;
      d_wait_wdata = dmem_wdata;
      // Both sides are stable until the edge, so acceptance is known here
      if (dmem_valid && dmem_ready) begin
        if (dmem_we) begin
          dmem[dmem_addr[11:2]] = dmem_wdata;
          wr_addr_q.push_back(dmem_addr);
        end else begin
          d_acc = 1;
          d_raddr = dmem_addr;
        end
      end
    end
  end

  // --------------------------------------------------
  // Instruction encoders
  // --------------------------------------------------
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return enc_i(imm, rs1, 3'b000, rd, OPC_OP_IMM);
  endfunction

  function automatic logic [31:0] enc_csrr(logic [4:0] rd, logic [11:0] csr);
    return enc_i(csr, 5'd0, 3'b010, rd, OPC_SYSTEM);
  endfunction

  // Arithmetic right shift built from logical shifts
  function automatic logic [31:0] shift_right_arith(logic [31:0] x, logic [4:0] s);
    return (x >> s) | (x[31] ? ~(32'hffff_ffff >> s) : 32'h0);
  endfunction

  function automatic logic [31:0] fill_word(int idx);
    return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0000;
  endfunction

  // --------------------------------------------------
  // Program building and running
  // --------------------------------------------------
  task automatic begin_test(input string name);
    cur_test = name;
    prog.delete();
    exp_q.delete();
  endtask

  task automatic emit(input logic [31:0] instr);
    prog.push_back(instr);
  endtask

  // Store rs to the next result slot and remember its expected value
  task automatic store_check(input logic [4:0] rs, input logic [31:0] expected);
    logic [11:0] off;
    off = 12'h100 + 12'(4 * exp_q.size());
    emit(enc_s(off, rs, 5'd0));
    exp_q.push_back(expected);
  endtask

  task automatic op_store(input logic [31:0] instr, input logic [31:0] expected);
    emit(instr);
    store_check(5'd10, expected);
  endtask

  task automatic run_program();
    int cyc;
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : INSTR_EBREAK;
      dmem[i] = fill_word(i);
    end
    wr_addr_q.delete();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    cyc = 0;
    while (!ebreak && cyc < 5000) begin
      @(negedge clk);
      cyc++;
    end
    if (!ebreak) begin
      $display("Timeout in %s: core never raised ebreak", cur_test);
      $display("CHECKS FAILED");
      $fatal(1, "halt wait expired");
    end
  endtask

  // Slots are written in program order
  task automatic check_results();
    check("store count", 32'(exp_q.size()), 32'(wr_addr_q.size()));
    for (int k = 0; k < exp_q.size(); k++) begin
      check($sformatf("store %0d address", k), 32'h100 + 32'(4 * k), wr_addr_q[k]);
      check($sformatf("slot %0d", k), exp_q[k], dmem[64 + k]);
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_alu();
    logic [31:0] a, b, c;
    a = 32'h8765_4321;
    b = 32'hffff_fff3;
    c = 32'd5;
    begin_test("alu");
    emit(enc_u(20'h87654, 5'd1, OPC_LUI));
    emit(enc_addi(5'd1, 5'd1, 12'h321));
    emit(enc_addi(5'd2, 5'd0, 12'hff3));
    emit(enc_addi(5'd3, 5'd0, 12'd5));
    op_store(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd10), a + b);
    op_store(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd10), a - b);
    op_store(enc_r(7'h00, 5'd3, 5'd2, 3'd2, 5'd10), {31'b0, $signed(b) < $signed(c)});
    op_store(enc_r(7'h00, 5'd3, 5'd2, 3'd3, 5'd10), {31'b0, b < c});
    op_store(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd10), a ^ b);
    op_store(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd10), a | b);
    op_store(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd10), a & b);
    op_store(enc_r(7'h00, 5'd3, 5'd1, 3'd1, 5'd10), a << 5);
    op_store(enc_r(7'h00, 5'd3, 5'd1, 3'd5, 5'd10), a >> 5);
    op_store(enc_r(7'h20, 5'd3, 5'd1, 3'd5, 5'd10), shift_right_arith(a, 5'd5));
    op_store(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd10), shift_right_arith(b, 5'd5));
    // Immediate forms
    op_store(enc_addi(5'd10, 5'd1, 12'hf9c), a + 32'hffff_ff9c);
    op_store(enc_i(12'hff4, 5'd2, 3'd2, 5'd10, OPC_OP_IMM), 32'd1);
    op_store(enc_i(12'hfff, 5'd3, 3'd3, 5'd10, OPC_OP_IMM), 32'd1);
    op_store(enc_i(12'h7ff, 5'd1, 3'd4, 5'd10, OPC_OP_IMM), a ^ 32'h7ff);
    op_store(enc_i(12'h0f0, 5'd2, 3'd6, 5'd10, OPC_OP_IMM), b | 32'h0f0);
    op_store(enc_i(12'h0ff, 5'd1, 3'd7, 5'd10, OPC_OP_IMM), a & 32'h0ff);
    op_store(enc_i(12'h007, 5'd1, 3'd1, 5'd10, OPC_OP_IMM), a << 7);
    op_store(enc_i(12'h009, 5'd1, 3'd5, 5'd10, OPC_OP_IMM), a >> 9);
    op_store(enc_i(12'h409, 5'd1, 3'd5, 5'd10, OPC_OP_IMM), shift_right_arith(a, 5'd9));
    op_store(enc_u(20'habcde, 5'd10, OPC_LUI), 32'habcd_e000);
    op_store(enc_u(20'h12345, 5'd10, OPC_AUIPC), 32'(4 * prog.size()) + 32'h1234_5000);
    run_program();
    check_results();
  endtask

  task automatic test_mem();
    logic [31:0] exp_addr [5];
    exp_addr = '{32'h200, 32'h204, 32'h208, 32'h20c, 32'h304};
    begin_test("memory");
    emit(enc_addi(5'd1, 5'd0, 12'h123));
    emit(enc_u(20'hdead0, 5'd2, OPC_LUI));
    emit(enc_addi(5'd2, 5'd2, 12'h7ef));
    emit(enc_s(12'h200, 5'd1, 5'd0));
    emit(enc_s(12'h204, 5'd2, 5'd0));
    emit(enc_i(12'h200, 5'd0, 3'd2, 5'd3, OPC_LOAD));
    emit(enc_i(12'h204, 5'd0, 3'd2, 5'd4, OPC_LOAD));
    emit(enc_r(7'h00, 5'd4, 5'd3, 3'd0, 5'd5));
    emit(enc_r(7'h20, 5'd3, 5'd4, 3'd0, 5'd6));
    emit(enc_i(12'h300, 5'd0, 3'd2, 5'd7, OPC_LOAD));
    emit(enc_addi(5'd7, 5'd7, 12'd1));
    emit(enc_s(12'h208, 5'd5, 5'd0));
    emit(enc_s(12'h20c, 5'd6, 5'd0));
    emit(enc_s(12'h304, 5'd7, 5'd0));
    run_program();
    check("word 0x200", 32'h0000_0123, dmem[12'h200 >> 2]);
    check("word 0x204", 32'hdead_07ef, dmem[12'h204 >> 2]);
    check("word 0x208", 32'hdead_0912, dmem[12'h208 >> 2]);
    check("word 0x20c", 32'hdead_06cc, dmem[12'h20c >> 2]);
    check("word 0x304", fill_word(12'h300 >> 2) + 32'd1, dmem[12'h304 >> 2]);
    check("word 0x308", fill_word(12'h308 >> 2), dmem[12'h308 >> 2]);
    check("store count", 32'd5, 32'(wr_addr_q.size()));
    for (int k = 0; k < 5; k++) begin
      check($sformatf("store %0d address", k), exp_addr[k], wr_addr_q[k]);
    end
  endtask

  // Taken path stores 2, fall-through stores 1
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic taken);
    emit(enc_b(13'd12, rs2, rs1, f3));
    emit(enc_addi(5'd10, 5'd0, 12'd1));
    emit(enc_j(21'd8, 5'd0));
    emit(enc_addi(5'd10, 5'd0, 12'd2));
    store_check(5'd10, taken ? 32'd2 : 32'd1);
  endtask

  task automatic test_branch();
    int n;
    begin_test("control flow");
    emit(enc_addi(5'd1, 5'd0, 12'hfff));
    emit(enc_addi(5'd2, 5'd0, 12'd1));
    // x1 holds -1, x2 holds 1
    branch_case(3'b000, 5'd1, 5'd1, 1'b1);
    branch_case(3'b000, 5'd1, 5'd2, 1'b0);
    branch_case(3'b001, 5'd1, 5'd2, 1'b1);
    branch_case(3'b001, 5'd1, 5'd1, 1'b0);
    branch_case(3'b100, 5'd1, 5'd2, 1'b1);
    branch_case(3'b100, 5'd2, 5'd1, 1'b0);
    branch_case(3'b101, 5'd2, 5'd1, 1'b1);
    branch_case(3'b101, 5'd1, 5'd2, 1'b0);
    branch_case(3'b110, 5'd2, 5'd1, 1'b1);
    branch_case(3'b110, 5'd1, 5'd2, 1'b0);
    branch_case(3'b111, 5'd1, 5'd2, 1'b1);
    branch_case(3'b111, 5'd2, 5'd1, 1'b0);
    n = prog.size();
    emit(enc_j(21'd8, 5'd5));
    emit(enc_addi(5'd11, 5'd0, 12'd1));
    store_check(5'd5, 32'(4 * n + 4));
    store_check(5'd11, 32'd0);
    // JALR through an odd address
    n = prog.size();
    emit(enc_addi(5'd6, 5'd0, 12'(4 * n + 13)));
    emit(enc_i(12'd0, 5'd6, 3'd0, 5'd7, OPC_JALR));
    emit(enc_addi(5'd12, 5'd0, 12'd1));
    store_check(5'd7, 32'(4 * n + 8));
    store_check(5'd12, 32'd0);
    run_program();
    check_results();
  endtask

  task automatic test_counters();
    begin_test("counters");
    emit(enc_csrr(5'd4, CSR_CYCLE));
    emit(enc_csrr(5'd1, CSR_INSTRET));
    repeat (3) emit(enc_addi(5'd0, 5'd0, 12'd0));
    emit(enc_csrr(5'd2, CSR_INSTRET));
    emit(enc_csrr(5'd5, CSR_CYCLE));
    emit(enc_csrr(5'd7, CSR_INSTRETH));
    emit(enc_csrr(5'd8, CSR_CYCLEH));
    emit(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
    emit(enc_r(7'h00, 5'd5, 5'd4, 3'd3, 5'd6));
    store_check(5'd3, 32'd4);
    store_check(5'd6, 32'd1);
    store_check(5'd7, 32'd0);
    store_check(5'd8, 32'd0);
    run_program();
    check_results();
  endtask

  task automatic test_halt();
    begin_test("halt and x0");
    emit(enc_addi(5'd0, 5'd0, 12'd55));
    emit(enc_u(20'h12345, 5'd0, OPC_LUI));
    emit(32'h0000_000f);
    emit(enc_addi(5'd1, 5'd0, 12'd9));
    emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
    store_check(5'd0, 32'd0);
    store_check(5'd1, 32'd9);
    emit(INSTR_EBREAK);
    run_program();
    check_results();
    repeat (50) begin
      @(negedge clk);
      check("ebreak held", 1, ebreak);
      check("no imem request", 0, imem_valid);
      check("no dmem request", 0, dmem_valid);
    end
  endtask

  initial begin
    void'($urandom(32'hfb9f));
    test_alu();
    test_mem();
    test_branch();
    test_counters();
    test_halt();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input logic clk,
  input logic rst_n,

  // Instruction memory
  output logic imem_valid,
  input logic imem_ready,
  output logic [rv_isa_pkg::XLEN-1:0] imem_addr,
  input logic imem_rvalid,
  input logic [rv_isa_pkg::XLEN-1:0] imem_rdata,

  // Data memory
  output logic dmem_valid,
  input logic dmem_ready,
  output logic dmem_we,
  output logic [rv_isa_pkg::XLEN-1:0] dmem_addr,
  output logic [rv_isa_pkg::XLEN-1:0] dmem_wdata,
  input logic dmem_rvalid,
  input logic [rv_isa_pkg::XLEN-1:0] dmem_rdata,

  output logic ebreak
);
  import rv_isa_pkg::*;

  logic            retire;
  logic [11:0]     csr_addr;
  logic [XLEN-1:0] csr_rdata;

  rv_ctrl_if ctrl_if ();

  rv_sequencer sequencer_inst (
    .clk(clk), .rst_n(rst_n), .ctrl(ctrl_if.seq),
    .imem_valid(imem_valid), .imem_ready(imem_ready), .imem_rvalid(imem_rvalid),
    .dmem_valid(dmem_valid), .dmem_we(dmem_we), .dmem_ready(dmem_ready),
    .dmem_rvalid(dmem_rvalid), .retire(retire), .halted(ebreak)
  );

  rv_datapath datapath_inst (
    .clk(clk), .rst_n(rst_n), .ctrl(ctrl_if.dp),
    .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
    .csr_addr(csr_addr), .csr_rdata(csr_rdata)
  );

  rv_counters counters_inst (
    .clk(clk), .rst_n(rst_n), .retire(retire),
    .csr_addr(csr_addr), .csr_rdata(csr_rdata)
  );

endmodule

/* hw/rv_datapath.sv */
`timescale 1ns/1ps

module rv_datapath (
  input logic clk,
  input logic rst_n,
  rv_ctrl_if.dp ctrl,
  output logic [rv_isa_pkg::XLEN-1:0] imem_addr,
  input logic [rv_isa_pkg::XLEN-1:0] imem_rdata,
  output logic [rv_isa_pkg::XLEN-1:0] dmem_addr,
  output logic [rv_isa_pkg::XLEN-1:0] dmem_wdata,
  input logic [rv_isa_pkg::XLEN-1:0] dmem_rdata,
  output logic [11:0] csr_addr,
  input logic [rv_isa_pkg::XLEN-1:0] csr_rdata
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [XLEN-1:0] pc, pc_plus4, target;
  logic [31:0]     ir;
  logic [XLEN-1:0] alu_q, mdr_q, csr_q;
  logic [XLEN-1:0] imm, rs1_data, rs2_data, wb_data;
  logic [XLEN-1:0] alu_a, alu_b, alu_result;

  // --------------------------------------------------
  // State registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (ctrl.pc_we) begin
      pc <= ctrl.pc_target ? target : pc_plus4;
    end
  end

  // Operands hold steady after EXECUTE, so these capture every cycle
  always_ff @(posedge clk) begin
    if (ctrl.ir_we) ir <= imem_rdata;
    if (ctrl.mdr_we) mdr_q <= dmem_rdata;
    alu_q <= alu_result;
    csr_q <= csr_rdata;
  end

  assign pc_plus4 = pc + 32'd4;
  assign target   = ctrl.jalr ? {alu_q[XLEN-1:1], 1'b0} : pc + imm;

  // Immediate forms
  always_comb begin
    case (ctrl.imm_type)
      IMM_S:   imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      IMM_B:   imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      IMM_U:   imm = {ir[31:12], 12'b0};
      IMM_J:   imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      default: imm = {{20{ir[31]}}, ir[31:20]};
    endcase
  end

  rv_regfile regfile_inst (
    .clk(clk), .rst_n(rst_n), .we(ctrl.reg_we),
    .ra1(ir[19:15]), .ra2(ir[24:20]), .wa(ir[11:7]), .wd(wb_data),
    .rd1(rs1_data), .rd2(rs2_data)
  );

  assign alu_a = (ctrl.a_src == A_PC) ? pc : rs1_data;
  assign alu_b = (ctrl.b_src == B_IMM) ? imm : rs2_data;

  rv_alu alu_inst (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .result(alu_result));

  // Branch compare
  always_comb begin
    case (branch_f3_t'(ir[14:12]))
      F3_BEQ:  ctrl.branch_taken = (rs1_data == rs2_data);
      F3_BNE:  ctrl.branch_taken = (rs1_data != rs2_data);
      F3_BLT:  ctrl.branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  ctrl.branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: ctrl.branch_taken = (rs1_data < rs2_data);
      F3_BGEU: ctrl.branch_taken = (rs1_data >= rs2_data);
      default: ctrl.branch_taken = 1'b0;
    endcase
  end

  // Writeback select
  always_comb begin
    case (ctrl.res_src)
      RES_MEM:      wb_data = mdr_q;
      RES_PC_PLUS4: wb_data = pc_plus4;
      RES_CSR:      wb_data = csr_q;
      RES_IMM:      wb_data = imm;
      default:      wb_data = alu_q;
    endcase
  end

  assign ctrl.opcode          = opcode_t'(ir[6:0]);
  assign ctrl.funct3          = ir[14:12];
  assign ctrl.funct7_b5       = ir[30];
  assign ctrl.instr_is_ebreak = (ir == INSTR_EBREAK);

  assign imem_addr  = pc;
  assign dmem_addr  = alu_q;
  assign dmem_wdata = rs2_data;
  assign csr_addr   = ir[31:20];

  // Jump targets and sequencing together keep fetches aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

/* hw/rv_counters.sv */
`timescale 1ns/1ps

module rv_counters (
  input logic clk,
  input logic rst_n,
  input logic retire,
  input logic [11:0] csr_addr,
  output logic [rv_isa_pkg::XLEN-1:0] csr_rdata
);
  import rv_isa_pkg::*;

  logic [63:0] cycle_q;
  logic [63:0] instret_q;

  // Free-running cycle count, instret bumps once per retirement
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q   <= '0;
      instret_q <= '0;
    end else begin
      cycle_q <= cycle_q + 64'd1;
      if (retire) begin
        instret_q <= instret_q + 64'd1;
      end
    end
  end

  // --------------------------------------------------
  // CSR read select
  // --------------------------------------------------
  always_comb begin
    case (csr_addr)
      CSR_CYCLE:    csr_rdata = cycle_q[XLEN-1:0];
      CSR_CYCLEH:   csr_rdata = cycle_q[63:XLEN];
      CSR_INSTRET:  csr_rdata = instret_q[XLEN-1:0];
      CSR_INSTRETH: csr_rdata = instret_q[63:XLEN];
      default:      csr_rdata = '0;
    endcase
  end

endmodule

/* hw/rv_sequencer.sv */
`timescale 1ns/1ps

module rv_sequencer (
  input logic clk,
  input logic rst_n,
  rv_ctrl_if.seq ctrl,
  output logic imem_valid,
  input logic imem_ready,
  input logic imem_rvalid,
  output logic dmem_valid,
  output logic dmem_we,
  input logic dmem_ready,
  input logic dmem_rvalid,
  output logic retire,
  output logic halted
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  seq_state_t state;
  seq_state_t state_next;
  logic       wr_rd;
  logic       is_mem;
  logic       is_store;

  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic b5,
                                         input logic reg_form);
    case (f3)
      3'b000:  return (b5 && reg_form) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return b5 ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // --------------------------------------------------
  // Instruction decode
  // --------------------------------------------------
  always_comb begin
    ctrl.alu_op    = ALU_ADD;
    ctrl.a_src     = A_RS1;
    ctrl.b_src     = B_IMM;
    ctrl.imm_type  = IMM_I;
    ctrl.res_src   = RES_ALU;
    ctrl.pc_target = 1'b0;
    ctrl.jalr      = 1'b0;
    wr_rd          = 1'b0;
    is_mem         = 1'b0;
    is_store       = 1'b0;
    case (ctrl.opcode)
      OPC_OP: begin
        ctrl.b_src  = B_RS2;
        ctrl.alu_op = alu_decode(ctrl.funct3, ctrl.funct7_b5, 1'b1);
        wr_rd       = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl.alu_op = alu_decode(ctrl.funct3, ctrl.funct7_b5, 1'b0);
        wr_rd       = 1'b1;
      end
      OPC_LUI: begin
        ctrl.imm_type = IMM_U;
        ctrl.res_src  = RES_IMM;
        wr_rd         = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.a_src    = A_PC;
        ctrl.imm_type = IMM_U;
        wr_rd         = 1'b1;
      end
      OPC_JAL: begin
        ctrl.imm_type  = IMM_J;
        ctrl.res_src   = RES_PC_PLUS4;
        ctrl.pc_target = 1'b1;
        wr_rd          = 1'b1;
      end
      OPC_JALR: begin
        ctrl.res_src   = RES_PC_PLUS4;
        ctrl.pc_target = 1'b1;
        ctrl.jalr      = 1'b1;
        wr_rd          = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl.imm_type  = IMM_B;
        ctrl.pc_target = ctrl.branch_taken;
      end
      OPC_LOAD: begin
        ctrl.res_src = RES_MEM;
        wr_rd        = 1'b1;
        is_mem       = 1'b1;
      end
      OPC_STORE: begin
        ctrl.imm_type = IMM_S;
        is_mem        = 1'b1;
        is_store      = 1'b1;
      end
      OPC_SYSTEM: begin
        // Only CSRRS counter reads write a result
        ctrl.res_src = RES_CSR;
        wr_rd        = (ctrl.funct3 == 3'b010);
      end
      default: ;
    endcase
  end

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      ST_FETCH:      if (imem_ready) state_next = ST_FETCH_WAIT;
      ST_FETCH_WAIT: if (imem_rvalid) state_next = ST_EXECUTE;
      ST_EXECUTE: begin
        if (ctrl.instr_is_ebreak) state_next = ST_HALT;
        else if (is_mem) state_next = ST_MEM_REQ;
        else state_next = ST_WRITEBACK;
      end
      ST_MEM_REQ:    if (dmem_ready) state_next = is_store ? ST_WRITEBACK : ST_MEM_WAIT;
      ST_MEM_WAIT:   if (dmem_rvalid) state_next = ST_WRITEBACK;
      ST_WRITEBACK:  state_next = ST_FETCH;
      default:       state_next = ST_HALT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_FETCH;
    end else begin
      state <= state_next;
    end
  end

  assign imem_valid  = (state == ST_FETCH);
  assign dmem_valid  = (state == ST_MEM_REQ);
  assign dmem_we     = dmem_valid && is_store;
  assign ctrl.ir_we  = (state == ST_FETCH_WAIT) && imem_rvalid;
  assign ctrl.mdr_we = (state == ST_MEM_WAIT) && dmem_rvalid;
  assign ctrl.reg_we = (state == ST_WRITEBACK) && wr_rd;
  assign ctrl.pc_we  = (state == ST_WRITEBACK);
  assign retire      = (state == ST_WRITEBACK);
  assign halted      = (state == ST_HALT);

  // Requests wait for ready
  a_imem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    imem_valid && !imem_ready |=> imem_valid);
  a_dmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_we));

endmodule

/* hw/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input logic [rv_isa_pkg::XLEN-1:0] a,
  input logic [rv_isa_pkg::XLEN-1:0] b,
  input rv_ctrl_pkg::alu_op_t op,
  output logic [rv_isa_pkg::XLEN-1:0] result
);
  import rv_ctrl_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  // --------------------------------------------------
  // Integer operations
  // --------------------------------------------------
  always_comb begin
    result = '0;
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result[0] = $signed(a) < $signed(b);
      ALU_SLTU: result[0] = a < b;
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input logic clk,
  input logic rst_n,
  input logic we,
  input logic [rv_isa_pkg::REG_AW-1:0] ra1,
  input logic [rv_isa_pkg::REG_AW-1:0] ra2,
  input logic [rv_isa_pkg::REG_AW-1:0] wa,
  input logic [rv_isa_pkg::XLEN-1:0] wd,
  output logic [rv_isa_pkg::XLEN-1:0] rd1,
  output logic [rv_isa_pkg::XLEN-1:0] rd2
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] regs [2**REG_AW];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // x0 reads as zero
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* hw/rv_ctrl_if.sv */
`timescale 1ns/1ps

interface rv_ctrl_if;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  // Sequencer to datapath
  logic      ir_we;
  logic      mdr_we;
  logic      reg_we;
  logic      pc_we;
  alu_op_t   alu_op;
  a_src_t    a_src;
  b_src_t    b_src;
  imm_type_t imm_type;
  res_src_t  res_src;
  logic      pc_target;
  logic      jalr;

  // Datapath back to sequencer
  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  logic       instr_is_ebreak;
  logic       branch_taken;

  modport seq(
    output ir_we, mdr_we, reg_we, pc_we, alu_op, a_src, b_src, imm_type, res_src,
           pc_target, jalr,
    input opcode, funct3, funct7_b5, instr_is_ebreak, branch_taken
  );

  modport dp(
    input ir_we, mdr_we, reg_we, pc_we, alu_op, a_src, b_src, imm_type, res_src,
          pc_target, jalr,
    output opcode, funct3, funct7_b5, instr_is_ebreak, branch_taken
  );

endinterface

/* hw/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_FETCH_WAIT,
    ST_EXECUTE,
    ST_MEM_REQ,
    ST_MEM_WAIT,
    ST_WRITEBACK,
    ST_HALT
  } seq_state_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // Writeback value select
  typedef enum logic [2:0] {RES_ALU, RES_MEM, RES_PC_PLUS4, RES_CSR, RES_IMM} res_src_t;

  // ALU operand selects
  typedef enum logic {A_RS1, A_PC} a_src_t;
  typedef enum logic {B_RS2, B_IMM} b_src_t;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_t;

endpackage

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  // --------------------------------------------------
  // Widths and reset vector
  // --------------------------------------------------
  localparam int XLEN = 32;
  localparam int REG_AW = 5;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // --------------------------------------------------
  // Major opcodes, bits [6:0]
  // --------------------------------------------------
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  // Branch conditions in funct3
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } branch_f3_t;

  // Zicntr counter CSRs
  localparam logic [11:0] CSR_CYCLE = 12'hc00;
  localparam logic [11:0] CSR_CYCLEH = 12'hc80;
  localparam logic [11:0] CSR_INSTRET = 12'hc02;
  localparam logic [11:0] CSR_INSTRETH = 12'hc82;

  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

endpackage
